/* source/wr_consts.svh */
/*
 * write-back stage constants
 * reset values of the general and segment registers, descriptor field positions
 */

`ifndef WR_CONSTS_SVH
`define WR_CONSTS_SVH

// ------------------------------------------------------------
// general registers after reset
// ------------------------------------------------------------
`define STARTUP_EAX         32'h0000_0000
`define STARTUP_ECX         32'h0000_0000
`define STARTUP_EDX         32'h0000_0543
`define STARTUP_EBX         32'h0000_0000
`define STARTUP_ESP         32'h0000_0000
`define STARTUP_EBP         32'h0000_0000
`define STARTUP_ESI         32'h0000_0000
`define STARTUP_EDI         32'h0000_0000

// ------------------------------------------------------------
// segment registers after reset
// ------------------------------------------------------------
`define STARTUP_SEG_SEL     16'h0000
`define STARTUP_CS_SEL      16'hF000
`define STARTUP_SEG_RPL     2'd0
`define STARTUP_SEG_VALID   1'b1

// base, flags, P, DPL, S, type, base, base, limit
`define DEFAULT_SEG_CACHE   {8'h00, 8'h00, 1'b1, 2'd0, 1'b1, 4'b0011, 8'h00, 16'h0000, 16'hFFFF}
// code segment at base FFFF0000
`define DEFAULT_CS_CACHE    {8'hFF, 8'h00, 1'b1, 2'd0, 1'b1, 4'b1011, 8'hFF, 16'h0000, 16'hFFFF}
`define DEFAULT_LDTR_CACHE  {8'h00, 8'h00, 1'b1, 2'd0, 1'b0, 4'd2, 8'h00, 16'h0000, 16'hFFFF}
`define DEFAULT_TR_CACHE    {8'h00, 8'h00, 1'b1, 2'd0, 1'b0, 4'd11, 8'h00, 16'h0000, 16'hFFFF}

// descriptor field positions
`define DESC_BIT_P          47
`define DESC_BIT_SEG        44
`define DESC_DPL_LO         45
`define DESC_TYPE_LO        40
`define DESC_ACCESSED_BIT   40
`define DESC_BUSY_BIT       41

`endif

/* source/gpr_pkg.sv */
/*
 * general register write-back types
 * register numbers, destination select, operand width and request records
 */

package gpr_pkg;

    // x86 encoding order of the general registers
    typedef enum logic [2:0] {
        gpr_eax = 3'd0,
        gpr_ecx,
        gpr_edx,
        gpr_ebx,
        gpr_esp,
        gpr_ebp,
        gpr_esi,
        gpr_edi
    } gpr_idx_t;

    typedef enum logic [1:0] {
        dst_none,
        dst_rm,
        dst_reg,
        dst_implicit
    } wr_dst_t;

    typedef enum logic [1:0] {
        width_byte,
        width_word,
        width_dword
    } op_width_t;

    typedef struct packed {
        logic        write_eax;
        logic        write_regrm;
        wr_dst_t     dst;
        gpr_idx_t    rm;
        gpr_idx_t    reg_idx;
        gpr_idx_t    implicit_idx;
        logic        is_8bit;
        logic        operand_32bit;
        logic        regrm_word;
        logic        regrm_dword;
        logic [31:0] result;
    } gpr_write_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] value;
    } esp_restore_t;

    typedef logic [7:0][31:0] gpr_array_t;

endpackage

/* source/seg_pkg.sv */
/*
 * segment register types
 * segment numbers, descriptors, write requests, segment state and mode writes
 */

package seg_pkg;

    typedef enum logic [2:0] {
        seg_es = 3'd0,
        seg_cs,
        seg_ss,
        seg_ds,
        seg_fs,
        seg_gs,
        seg_ldtr,
        seg_tr
    } seg_idx_t;

    typedef logic [63:0] desc_t;

    // ------------------------------------------------------------
    // requests
    // ------------------------------------------------------------
    typedef struct packed {
        seg_idx_t    idx;
        logic        write_sel;
        logic        write_rpl;
        logic        write_cache;
        logic        write_valid;
        logic [15:0] sel;
        logic [1:0]  rpl;
        logic        cache_valid;
        desc_t       descriptor;
        desc_t       mask;
        logic        touch;
        logic        busy_tss;
    } seg_write_t;

    // one slot's view, descriptor already merged
    typedef struct packed {
        logic        write_sel;
        logic        write_rpl;
        logic        write_cache;
        logic        write_valid;
        logic [15:0] sel;
        logic [1:0]  rpl;
        logic        cache_valid;
        desc_t       descriptor;
        desc_t       mask;
    } slot_write_t;

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------
    typedef struct packed {
        logic [15:0] sel;
        logic [1:0]  rpl;
        desc_t       cache;
        logic        valid;
    } seg_reg_t;

    typedef seg_reg_t [7:0] seg_array_t;

    typedef struct packed {
        logic       en;
        logic       pe;
        logic       vm;
        logic [1:0] iopl;
    } mode_write_t;

endpackage

/* source/gpr_file.sv */
/*
 * general register file
 * eight 32-bit registers with byte, word and dword write merge
 * and ESP restore on exception
 */

`include "wr_consts.svh"

module gpr_file import gpr_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  gpr_write_t   wr,
    input  esp_restore_t esp_restore,
    output gpr_array_t   gprs
);

    gpr_idx_t   idx;
    op_width_t  width;
    logic       do_write;
    gpr_array_t gprs_next;

    // ------------------------------------------------------------
    // destination and width
    // ------------------------------------------------------------
    always_comb begin
        case (wr.dst)
            dst_rm:       idx = wr.rm;
            dst_reg:      idx = wr.reg_idx;
            dst_implicit: idx = wr.implicit_idx;
            default:      idx = gpr_eax;
        endcase
    end

    assign do_write = wr.write_eax || (wr.write_regrm && wr.dst != dst_none);

    // byte mode overrides the word/dword selection
    always_comb begin
        if (wr.is_8bit) begin
            width = width_byte;
        end else if (wr.regrm_word) begin
            width = width_word;
        end else if (wr.regrm_dword) begin
            width = width_dword;
        end else begin
            width = wr.operand_32bit ? width_dword : width_word;
        end
    end

    // ------------------------------------------------------------
    // merge
    // ------------------------------------------------------------
    always_comb begin
        gprs_next = gprs;
        if (do_write) begin
            case (width)
                width_byte: begin
                    // AH, CH, DH, BH live in bits 15:8 of registers 0-3
                    if (idx[2]) begin
                        gprs_next[idx[1:0]][15:8] = wr.result[7:0];
                    end else begin
                        gprs_next[idx[1:0]][7:0] = wr.result[7:0];
                    end
                end
                width_word: gprs_next[idx][15:0] = wr.result[15:0];
                default:    gprs_next[idx] = wr.result;
            endcase
        end else if (esp_restore.valid) begin
            gprs_next[gpr_esp] = esp_restore.value;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gprs <= {`STARTUP_EDI, `STARTUP_ESI, `STARTUP_EBP, `STARTUP_ESP,
                     `STARTUP_EBX, `STARTUP_EDX, `STARTUP_ECX, `STARTUP_EAX};
        end else begin
            gprs <= gprs_next;
        end
    end

    // decoder never asks for both forced widths
    a_width_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(wr.regrm_word && wr.regrm_dword)
    );

endmodule

/* source/seg_write_decode.sv */
/*
 * segment write decoder
 * splits one segment request into per-slot strobes and merges the
 * accessed or busy bit into the descriptor
 */

`include "wr_consts.svh"

module seg_write_decode import seg_pkg::*; (
    input  logic              clk,
    input  seg_write_t        wr,
    output slot_write_t [7:0] slots
);

    desc_t      merged;

    // touch wins over busy
    always_comb begin
        merged = wr.descriptor;
        if (wr.touch) begin
            merged[`DESC_ACCESSED_BIT] = 1'b1;
        end else if (wr.busy_tss) begin
            merged[`DESC_BUSY_BIT] = 1'b1;
        end
    end

    for (genvar i = 0; i < 8; i++) begin : g_slot
        logic hit;

        assign hit = (wr.idx == seg_idx_t'(i));

        assign slots[i].write_sel   = wr.write_sel & hit;
        assign slots[i].write_rpl   = wr.write_rpl & hit;
        assign slots[i].write_cache = wr.write_cache & hit;
        assign slots[i].write_valid = wr.write_valid & hit;

        // data is shared by all slots
        assign slots[i].sel         = wr.sel;
        assign slots[i].rpl         = wr.rpl;
        assign slots[i].cache_valid = wr.cache_valid;
        assign slots[i].descriptor  = merged;
        assign slots[i].mask        = wr.mask;
    end

    // a request with strobes must name a slot
    a_known_idx: assert property (
        @(posedge clk)
        (wr.write_sel | wr.write_rpl | wr.write_cache | wr.write_valid) |-> !$isunknown(wr.idx)
    );

endmodule

/* source/seg_slot.sv */
/*
 * one segment register
 * selector, RPL, descriptor cache and valid bit, with mask merge,
 * LDTR present check and privilege-based invalidation
 */

`include "wr_consts.svh"

module seg_slot import seg_pkg::*; #(
    parameter seg_idx_t SLOT = seg_es
) (
    input  logic        clk,
    input  logic        rst_n,
    input  slot_write_t wr,
    input  logic        validate,
    input  logic [1:0]  cpl,
    output seg_reg_t    seg
);

    // ------------------------------------------------------------
    // per-slot reset value and rules
    // ------------------------------------------------------------
    localparam logic [15:0] RESET_SEL = (SLOT == seg_cs) ? `STARTUP_CS_SEL : `STARTUP_SEG_SEL;

    localparam desc_t RESET_CACHE =
        (SLOT == seg_cs)   ? desc_t'(`DEFAULT_CS_CACHE) :
        (SLOT == seg_ldtr) ? desc_t'(`DEFAULT_LDTR_CACHE) :
        (SLOT == seg_tr)   ? desc_t'(`DEFAULT_TR_CACHE) :
                             desc_t'(`DEFAULT_SEG_CACHE);

    // only data segment registers get dropped on a privilege change
    localparam logic CAN_INVALIDATE = (SLOT == seg_es) || (SLOT == seg_ds) ||
                                      (SLOT == seg_fs) || (SLOT == seg_gs);

    localparam logic NEEDS_PRESENT = (SLOT == seg_ldtr);

    logic [1:0] dpl;
    logic       is_code;
    logic       conforming;
    logic       invalidate;
    logic       present_ok;

    assign dpl        = seg.cache[`DESC_DPL_LO +: 2];
    assign is_code    = seg.cache[`DESC_TYPE_LO + 3];
    assign conforming = seg.cache[`DESC_TYPE_LO + 2];

    assign invalidate = CAN_INVALIDATE && validate && (dpl < cpl) &&
                        (!seg.valid || !seg.cache[`DESC_BIT_SEG] || !is_code || !conforming);

    // LDTR keeps its old cache when loaded with a not-present descriptor
    assign present_ok = !NEEDS_PRESENT || wr.descriptor[`DESC_BIT_P];

    // ------------------------------------------------------------
    // register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seg.sel   <= RESET_SEL;
            seg.rpl   <= `STARTUP_SEG_RPL;
            seg.cache <= RESET_CACHE;
            seg.valid <= `STARTUP_SEG_VALID;
        end else begin
            if (invalidate) begin
                seg.sel   <= 16'h0000;
                seg.valid <= 1'b0;
            end else begin
                if (wr.write_sel) begin
                    seg.sel <= wr.sel;
                end
                if (wr.write_valid) begin
                    seg.valid <= wr.cache_valid;
                end
            end
            if (wr.write_rpl && present_ok) begin
                seg.rpl <= wr.rpl;
            end
            // mask keeps old bits, descriptor sets new ones
            if (wr.write_cache && present_ok) begin
                seg.cache <= (seg.cache & wr.mask) | wr.descriptor;
            end
        end
    end

endmodule

/* source/seg_status.sv */
/*
 * mode register and derived status
 * CPL, real/protected/v8086 mode and the I/O permission check flag
 */

module seg_status import seg_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  seg_array_t  segs,
    input  mode_write_t mode_wr,
    output logic [1:0]  cpl,
    output logic        protected_mode,
    output logic        v8086_mode,
    output logic        real_mode,
    output logic        io_allow_check_needed
);

    logic       pe;
    logic       vm;
    logic [1:0] iopl;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pe   <= 1'b0;
            vm   <= 1'b0;
            iopl <= 2'd0;
        end else if (mode_wr.en) begin
            pe   <= mode_wr.pe;
            vm   <= mode_wr.vm;
            iopl <= mode_wr.iopl;
        end
    end

    // current privilege is the RPL of CS
    assign cpl = segs[seg_cs].rpl;

    assign protected_mode = pe && !vm;
    assign v8086_mode     = pe && vm;
    assign real_mode      = !pe;

    assign io_allow_check_needed = pe && (vm || cpl > iopl);

    // a mode write carries defined values
    a_mode_known: assert property (
        @(posedge clk) disable iff (!rst_n) mode_wr.en |-> !$isunknown(mode_wr)
    );

endmodule

/* source/wr_stage_top.sv */
/*
 * register write-back stage
 * general register file, segment decoder, eight segment slots and mode status
 */

module wr_stage_top import gpr_pkg::*, seg_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  gpr_write_t   gpr_wr,
    input  esp_restore_t esp_restore,
    input  seg_write_t   seg_wr,
    input  logic         validate_seg_regs,
    input  mode_write_t  mode_wr,
    output gpr_array_t   gprs,
    output seg_array_t   segs,
    output logic [1:0]   cpl,
    output logic         protected_mode,
    output logic         v8086_mode,
    output logic         real_mode,
    output logic         io_allow_check_needed
);

    slot_write_t [7:0] slot_wr;

    gpr_file i_gpr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (gpr_wr),
        .esp_restore (esp_restore),
        .gprs        (gprs)
    );

    // ------------------------------------------------------------
    // segment registers
    // ------------------------------------------------------------
    seg_write_decode i_seg_write_decode (
        .clk   (clk),
        .wr    (seg_wr),
        .slots (slot_wr)
    );

    for (genvar i = 0; i < 8; i++) begin : g_seg
        seg_slot #(
            .SLOT (seg_idx_t'(i))
        ) i_seg_slot (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr       (slot_wr[i]),
            .validate (validate_seg_regs),
            .cpl      (cpl),
            .seg      (segs[i])
        );
    end

    // cpl loops back into the slots for invalidation
    seg_status i_seg_status (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .segs                  (segs),
        .mode_wr               (mode_wr),
        .cpl                   (cpl),
        .protected_mode        (protected_mode),
        .v8086_mode            (v8086_mode),
        .real_mode             (real_mode),
        .io_allow_check_needed (io_allow_check_needed)
    );

endmodule

/* verif/wr_stage_tb.sv */
/*
 * write-back stage testbench
 * random requests from an xorshift source, checked every cycle against a register model
 */

`include "wr_consts.svh"

module wr_stage_tb import gpr_pkg::*, seg_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int GPR_CYCLES   = 300;
    localparam int ESP_CYCLES   = 150;
    localparam int SEG_CYCLES   = 300;
    localparam int VAL_CYCLES   = 200;
    localparam int MODE_CYCLES  = 150;
    // one settle cycle per test on top of the stimulus
    localparam int TOTAL_CYCLES = RESET_CYCLES + GPR_CYCLES + ESP_CYCLES + SEG_CYCLES +
                                  VAL_CYCLES + MODE_CYCLES + 6;
    localparam int TIMEOUT      = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    localparam int K_GPR  = 1;
    localparam int K_ESP  = 2;
    localparam int K_SEG  = 3;
    localparam int K_VAL  = 4;
    localparam int K_MODE = 5;

    logic         clk;
    logic         rst_n;
    gpr_write_t   gpr_wr;
    esp_restore_t esp_restore;
    seg_write_t   seg_wr;
    logic         validate_seg_regs;
    mode_write_t  mode_wr;
    gpr_array_t   gprs;
    seg_array_t   segs;
    logic [1:0]   cpl;
    logic         protected_mode;
    logic         v8086_mode;
    logic         real_mode;
    logic         io_allow_check_needed;

    // reference model state
    logic [31:0] m_gpr [8];
    logic [15:0] m_sel [8];
    logic [1:0]  m_rpl [8];
    logic [63:0] m_cache [8];
    logic        m_valid [8];
    logic        m_pe;
    logic        m_vm;
    logic [1:0]  m_iopl;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests;

    wr_stage_top i_wr_stage_top (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .gpr_wr                (gpr_wr),
        .esp_restore           (esp_restore),
        .seg_wr                (seg_wr),
        .validate_seg_regs     (validate_seg_regs),
        .mode_wr               (mode_wr),
        .gprs                  (gprs),
        .segs                  (segs),
        .cpl                   (cpl),
        .protected_mode        (protected_mode),
        .v8086_mode            (v8086_mode),
        .real_mode             (real_mode),
        .io_allow_check_needed (io_allow_check_needed)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // random source and checker
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_all();
        logic [1:0] exp_cpl;
        exp_cpl = m_rpl[1];
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("gprs[%0d]", i), 128'(gprs[i]), 128'(m_gpr[i]));
            check_value($sformatf("segs[%0d].sel", i), 128'(segs[i].sel), 128'(m_sel[i]));
            check_value($sformatf("segs[%0d].rpl", i), 128'(segs[i].rpl), 128'(m_rpl[i]));
            check_value($sformatf("segs[%0d].cache", i), 128'(segs[i].cache),
                        128'(m_cache[i]));
            check_value($sformatf("segs[%0d].valid", i), 128'(segs[i].valid),
                        128'(m_valid[i]));
        end
        check_value("cpl", 128'(cpl), 128'(exp_cpl));
        check_value("protected_mode", 128'(protected_mode), 128'(m_pe && !m_vm));
        check_value("v8086_mode", 128'(v8086_mode), 128'(m_pe && m_vm));
        check_value("real_mode", 128'(real_mode), 128'(!m_pe));
        check_value("io_allow_check_needed", 128'(io_allow_check_needed),
                    128'(m_pe && (m_vm || exp_cpl > m_iopl)));
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    task automatic model_reset();
        m_gpr[0] = `STARTUP_EAX;
        m_gpr[1] = `STARTUP_ECX;
        m_gpr[2] = `STARTUP_EDX;
        m_gpr[3] = `STARTUP_EBX;
        m_gpr[4] = `STARTUP_ESP;
        m_gpr[5] = `STARTUP_EBP;
        m_gpr[6] = `STARTUP_ESI;
        m_gpr[7] = `STARTUP_EDI;
        for (int s = 0; s < 8; s++) begin
            m_sel[s]   = (s == 1) ? `STARTUP_CS_SEL : `STARTUP_SEG_SEL;
            m_rpl[s]   = `STARTUP_SEG_RPL;
            m_cache[s] = `DEFAULT_SEG_CACHE;
            m_valid[s] = `STARTUP_SEG_VALID;
        end
        m_cache[1] = `DEFAULT_CS_CACHE;
        m_cache[6] = `DEFAULT_LDTR_CACHE;
        m_cache[7] = `DEFAULT_TR_CACHE;
        m_pe   = 1'b0;
        m_vm   = 1'b0;
        m_iopl = 2'd0;
    endtask

    // applies the requests now on the inputs, as the coming rising edge will
    task automatic model_step();
        logic [2:0]  idx;
        logic [63:0] desc;
        logic [1:0]  cur_cpl;
        logic [1:0]  dpl;
        logic        inv;
        logic        hit;
        logic        ok;
        case (gpr_wr.dst)
            dst_rm:       idx = gpr_wr.rm;
            dst_reg:      idx = gpr_wr.reg_idx;
            dst_implicit: idx = gpr_wr.implicit_idx;
            default:      idx = 3'd0;
        endcase
        if (gpr_wr.write_eax || (gpr_wr.write_regrm && gpr_wr.dst != dst_none)) begin
            if (gpr_wr.is_8bit && idx[2]) begin
                m_gpr[idx[1:0]][15:8] = gpr_wr.result[7:0];
            end else if (gpr_wr.is_8bit) begin
                m_gpr[idx[1:0]][7:0] = gpr_wr.result[7:0];
            end else if (gpr_wr.regrm_word ||
                         (!gpr_wr.regrm_dword && !gpr_wr.operand_32bit)) begin
                m_gpr[idx][15:0] = gpr_wr.result[15:0];
            end else begin
                m_gpr[idx] = gpr_wr.result;
            end
        end else if (esp_restore.valid) begin
            m_gpr[4] = esp_restore.value;
        end

        desc = seg_wr.descriptor;
        if (seg_wr.touch) begin
            desc[`DESC_ACCESSED_BIT] = 1'b1;
        end else if (seg_wr.busy_tss) begin
            desc[`DESC_BUSY_BIT] = 1'b1;
        end
        cur_cpl = m_rpl[1];
        for (int s = 0; s < 8; s++) begin
            dpl = m_cache[s][`DESC_DPL_LO +: 2];
            // ES, DS, FS and GS only
            inv = (s == 0 || s == 3 || s == 4 || s == 5) && validate_seg_regs &&
                  (dpl < cur_cpl) &&
                  (!m_valid[s] || !m_cache[s][`DESC_BIT_SEG] ||
                   !m_cache[s][`DESC_TYPE_LO + 3] || !m_cache[s][`DESC_TYPE_LO + 2]);
            hit = (int'(seg_wr.idx) == s);
            ok  = (s != 6) || desc[`DESC_BIT_P];
            if (inv) begin
                m_sel[s]   = 16'h0000;
                m_valid[s] = 1'b0;
            end else begin
                if (hit && seg_wr.write_sel) m_sel[s] = seg_wr.sel;
                if (hit && seg_wr.write_valid) m_valid[s] = seg_wr.cache_valid;
            end
            if (hit && seg_wr.write_rpl && ok) m_rpl[s] = seg_wr.rpl;
            if (hit && seg_wr.write_cache && ok) begin
                m_cache[s] = (m_cache[s] & seg_wr.mask) | desc;
            end
        end

        if (mode_wr.en) begin
            m_pe   = mode_wr.pe;
            m_vm   = mode_wr.vm;
            m_iopl = mode_wr.iopl;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic drive_idle();
        gpr_wr            = '0;
        esp_restore       = '0;
        seg_wr            = '0;
        validate_seg_regs = 1'b0;
        mode_wr           = '0;
    endtask

    task automatic drive_gpr(input logic with_restore);
        logic [31:0] r;
        r = next_rand();
        gpr_wr.write_eax     = (r[3:0] == 4'd0);
        // fewer writes when restores compete for ESP
        gpr_wr.write_regrm   = with_restore ? (r[4] & r[5]) : (r[4] | r[5]);
        gpr_wr.dst           = wr_dst_t'(r[7:6]);
        gpr_wr.rm            = gpr_idx_t'(r[10:8]);
        gpr_wr.reg_idx       = gpr_idx_t'(r[13:11]);
        gpr_wr.implicit_idx  = gpr_idx_t'(r[16:14]);
        gpr_wr.is_8bit       = r[17] & r[18];
        gpr_wr.operand_32bit = r[19];
        gpr_wr.regrm_word    = r[20] & r[21];
        gpr_wr.regrm_dword   = r[22] & r[23] & !(r[20] & r[21]);
        gpr_wr.result        = next_rand();
        esp_restore.valid    = with_restore & (r[24] | r[25]);
        esp_restore.value    = next_rand();
    endtask

    task automatic drive_seg(input logic keep_cpl);
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = next_rand();
        a = next_rand();
        b = next_rand();
        seg_wr.idx         = seg_idx_t'(r[2:0]);
        seg_wr.write_sel   = r[3];
        seg_wr.write_rpl   = r[4] & !(keep_cpl && r[2:0] == 3'd1);
        seg_wr.write_cache = r[5];
        seg_wr.write_valid = r[6];
        seg_wr.rpl         = r[8:7];
        seg_wr.cache_valid = r[9];
        seg_wr.sel         = a[15:0];
        seg_wr.descriptor  = {a, b};
        seg_wr.mask        = (r[10] || keep_cpl) ? 64'h0 : {next_rand(), next_rand()};
        seg_wr.touch       = r[11] & r[12];
        seg_wr.busy_tss    = r[13] & r[14];
        validate_seg_regs  = keep_cpl & r[15];
    endtask

    task automatic drive_mode();
        logic [31:0] r;
        r = next_rand();
        mode_wr.en       = r[0] | r[1];
        mode_wr.pe       = r[2] | r[3];
        mode_wr.vm       = r[4];
        mode_wr.iopl     = r[6:5];
        seg_wr.idx       = seg_cs;
        seg_wr.write_rpl = r[7];
        seg_wr.rpl       = r[9:8];
    endtask

    task automatic run_test(input string name, input int kind, input int cycles);
        int start_err;
        start_err = errors;
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            compare_all();
            drive_idle();
            case (kind)
                K_GPR:  drive_gpr(1'b0);
                K_ESP:  drive_gpr(1'b1);
                K_SEG:  drive_seg(1'b0);
                K_VAL: begin
                    if (n == 0) begin
                        seg_wr.idx       = seg_cs;
                        seg_wr.write_rpl = 1'b1;
                        seg_wr.rpl       = 2'd3;
                    end else begin
                        drive_seg(1'b1);
                    end
                end
                default: drive_mode();
            endcase
            model_step();
        end
        // last request checked here
        @(negedge clk);
        compare_all();
        drive_idle();
        model_step();
        tests++;
        $display("test %-14s %0d cycles, %0d errors", name, cycles, errors - start_err);
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        rng_state = 32'hef3c;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        rst_n     = 1'b0;
        drive_idle();
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_all();
        tests++;
        $display("test %-14s %0d errors", "reset", errors);

        run_test("gpr_writes", K_GPR, GPR_CYCLES);
        run_test("esp_restore", K_ESP, ESP_CYCLES);
        run_test("seg_writes", K_SEG, SEG_CYCLES);
        run_test("seg_validate", K_VAL, VAL_CYCLES);
        run_test("mode_writes", K_MODE, MODE_CYCLES);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/gpr_pkg.sv
source/seg_pkg.sv
source/gpr_file.sv
source/seg_write_decode.sv
source/seg_slot.sv
source/seg_status.sv
source/wr_stage_top.sv
verif/wr_stage_tb.sv

/* run.sh */
#!/bin/sh
# builds the write-back stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module wr_stage_tb -f files.f -o wr_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/wr_stage_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    exit 1
fi
